/* design/rv_pkg.sv */
// Shared RV32I core types and encodings, imported by every design module
package rv_pkg;

    // Datapath and address width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // Decoded operation carried from decode into execute
    // ADDI shares OP_ADD, second operand is then the immediate
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SLT = 4'd6,
        OP_LUI = 4'd7,
        OP_LW  = 4'd8,
        OP_SW  = 4'd9,
        OP_BEQ = 4'd10,
        OP_BNE = 4'd11,
        OP_JAL = 4'd12
    } op_e;

    ////////////////////////////////////////////////////////////
    // Major opcodes, instruction bits 6:0
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

/* design/mem_arbiter.sv */
// Fixed-priority arbiter putting data and fetch requests onto the single memory bus
`timescale 1ns/1ns

module mem_arbiter
    import rv_pkg::*;
(
    input  logic  fetch_req_i,
    input  word_t fetch_addr_i,
    input  logic  data_req_i,
    input  logic  data_we_i,
    input  word_t data_addr_i,
    input  word_t data_wdata_i,
    output logic  fetch_gnt_o,
    output logic  bus_en_o,
    output logic  bus_we_o,
    output word_t bus_addr_o,
    output word_t bus_wdata_o
);

    // Data first, fetch retries on a lost grant
    assign fetch_gnt_o = fetch_req_i && !data_req_i;

    assign bus_en_o    = data_req_i || fetch_req_i;
    assign bus_we_o    = data_req_i && data_we_i;
    assign bus_addr_o  = data_req_i ? data_addr_i : fetch_addr_i;
    // Only sampled with bus_we_o
    assign bus_wdata_o = data_wdata_i;

endmodule

/* design/reg_bank.sv */
// General register file with two read ports and same-cycle write forwarding
`timescale 1ns/1ns

module reg_bank
    import rv_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  logic     we_i,
    input  reg_idx_t rd_i,
    input  word_t    wdata_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);

    // Registers 1 to 31 only since x0 always reads as zero
    word_t regs_q [1:31];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // Write-through so that a retiring value is seen by decode in the same cycle
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (we_i && rd_i == rs1_i) ? wdata_i : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (we_i && rd_i == rs2_i) ? wdata_i : regs_q[rs2_i];

endmodule

/* design/fetch_unit.sv */
// Fetch stage: program counter, bus read request and the instruction register for decode
`timescale 1ns/1ns

module fetch_unit
    import rv_pkg::*;
#(
    parameter word_t RESET_ADDR = '0
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  stall_i,
    input  logic  hazard_i,
    input  logic  redirect_i,
    input  word_t redirect_target_i,
    input  logic  fetch_gnt_i,
    input  word_t bus_rdata_i,
    output logic  fetch_req_o,
    output word_t fetch_addr_o,
    output word_t instr_o,
    output logic  instr_valid_o,
    output word_t pc_o
);

    word_t pc_q;
    logic  pend_q;
    logic  run_q;
    logic  hold;

    // Hazard or external stall keeps the current instruction in place
    assign hold = stall_i || hazard_i;

    // No request on a redirect, the old path is dead
    assign fetch_req_o  = run_q && !hold && !redirect_i;
    // pc_q is the address whose data is on the bus when pend_q is set
    assign fetch_addr_o = pend_q ? pc_q + 32'd4 : pc_q;

    ////////////////////////////////////////////////////////////
    // PC and pending read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q          <= RESET_ADDR;
            pend_q        <= 1'b0;
            run_q         <= 1'b0;
            instr_valid_o <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                // In-flight read belongs to the wrong path, drop it
                pc_q          <= redirect_target_i;
                pend_q        <= 1'b0;
                instr_valid_o <= 1'b0;
            end else if (!hold) begin
                pc_q          <= fetch_addr_o;
                pend_q        <= fetch_gnt_i;
                instr_valid_o <= pend_q;
            end else begin
                // Held with data arriving, refetch pc_q later
                pend_q <= 1'b0;
            end
        end
    end

    // Instruction and its PC, captured one cycle after the grant
    always_ff @(posedge clk_i) begin
        if (!redirect_i && !hold && pend_q) begin
            instr_o <= bus_rdata_i;
            pc_o    <= pc_q;
        end
    end

endmodule

/* design/decode_unit.sv */
// Decode stage: field decoding, immediates, operand read, hazard check and the execute register
`timescale 1ns/1ns

module decode_unit
    import rv_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  word_t    instr_i,
    input  logic     instr_valid_i,
    input  word_t    pc_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    input  logic     flush_i,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output logic     hazard_o,
    output op_e      op_o,
    output word_t    opa_o,
    output word_t    opb_o,
    output word_t    store_data_o,
    output word_t    imm_o,
    output word_t    pc_ex_o,
    output reg_idx_t rd_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_fmt;
    word_t      imm_s_fmt;
    word_t      imm_b_fmt;
    word_t      imm_u_fmt;
    word_t      imm_j_fmt;
    op_e        dec_op;
    word_t      dec_opb;
    word_t      dec_imm;
    reg_idx_t   dec_rd;
    logic       bubble;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    ////////////////////////////////////////////////////////////
    // Immediate formats
    ////////////////////////////////////////////////////////////

    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
    assign imm_u_fmt = {instr_i[31:12], 12'b0};
    assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

    // Operation select, unknown encodings fall through as NOP
    always_comb begin
        dec_op  = OP_NOP;
        dec_opb = rs2_data_i;
        dec_imm = imm_i_fmt;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  dec_op = OP_ADD;
                        3'b010:  dec_op = OP_SLT;
                        3'b100:  dec_op = OP_XOR;
                        3'b110:  dec_op = OP_OR;
                        3'b111:  dec_op = OP_AND;
                        default: dec_op = OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_op = OP_SUB;
                end
            end
            OPC_OP_IMM: begin
                // ADDI only
                if (funct3 == 3'b000) begin
                    dec_op  = OP_ADD;
                    dec_opb = imm_i_fmt;
                end
            end
            OPC_LUI: begin
                dec_op  = OP_LUI;
                dec_opb = imm_u_fmt;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec_op = OP_LW;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    dec_op  = OP_SW;
                    dec_imm = imm_s_fmt;
                end
            end
            OPC_BRANCH: begin
                dec_imm = imm_b_fmt;
                if (funct3 == 3'b000) begin
                    dec_op = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    dec_op = OP_BNE;
                end
            end
            OPC_JAL: begin
                dec_op  = OP_JAL;
                dec_imm = imm_j_fmt;
            end
            default: dec_op = OP_NOP;
        endcase
    end

    // rd is zero for anything that does not write the bank
    assign dec_rd = (dec_op == OP_NOP || dec_op == OP_SW || dec_op == OP_BEQ ||
                     dec_op == OP_BNE) ? '0 : instr_i[11:7];

    // Writer still in execute, its value reaches the bank only at retire
    // Covers the LW load-use case and plain back-to-back ALU dependencies
    assign hazard_o = instr_valid_i && (rd_o != '0) && (rd_o == rs1_o || rd_o == rs2_o);

    assign bubble = flush_i || hazard_o || !instr_valid_i;

    ////////////////////////////////////////////////////////////
    // Decode to execute register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_o <= OP_NOP;
            rd_o <= '0;
        end else if (!stall_i) begin
            op_o <= bubble ? OP_NOP : dec_op;
            rd_o <= bubble ? '0 : dec_rd;
        end
    end

    // Operands, meaningless under a bubble
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            opa_o        <= rs1_data_i;
            opb_o        <= dec_opb;
            store_data_o <= rs2_data_i;
            imm_o        <= dec_imm;
            pc_ex_o      <= pc_i;
        end
    end

endmodule

/* design/exec_unit.sv */
// Execute stage: ALU, branch resolution, load/store requests and the retire register
`timescale 1ns/1ns

module exec_unit
    import rv_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  op_e      op_i,
    input  word_t    opa_i,
    input  word_t    opb_i,
    input  word_t    store_data_i,
    input  word_t    imm_i,
    input  word_t    pc_i,
    input  reg_idx_t rd_i,
    input  word_t    bus_rdata_i,
    output logic     data_req_o,
    output logic     data_we_o,
    output word_t    data_addr_o,
    output word_t    data_wdata_o,
    output logic     redirect_o,
    output word_t    redirect_target_o,
    output logic     rf_we_o,
    output reg_idx_t rf_rd_o,
    output word_t    rf_wdata_o
);

    word_t    alu_res;
    logic     taken;
    logic     we_q;
    logic     ld_q;
    reg_idx_t rd_q;
    word_t    res_q;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            OP_ADD:  alu_res = opa_i + opb_i;
            OP_SUB:  alu_res = opa_i - opb_i;
            OP_AND:  alu_res = opa_i & opb_i;
            OP_OR:   alu_res = opa_i | opb_i;
            OP_XOR:  alu_res = opa_i ^ opb_i;
            OP_SLT:  alu_res = {31'b0, $signed(opa_i) < $signed(opb_i)};
            OP_LUI:  alu_res = opb_i;
            // Link value
            OP_JAL:  alu_res = pc_i + 32'd4;
            default: alu_res = '0;
        endcase
    end

    // Branch and jump resolution
    assign taken = (op_i == OP_BEQ && opa_i == opb_i) ||
                   (op_i == OP_BNE && opa_i != opb_i) ||
                   (op_i == OP_JAL);

    // One pulse only, the stage is frozen while stalled
    assign redirect_o        = taken && !stall_i;
    assign redirect_target_o = pc_i + imm_i;

    // Word access, address is rs1 plus offset
    assign data_req_o   = (op_i == OP_LW || op_i == OP_SW) && !stall_i;
    assign data_we_o    = op_i == OP_SW;
    assign data_addr_o  = opa_i + imm_i;
    assign data_wdata_o = store_data_i;

    ////////////////////////////////////////////////////////////
    // Retire register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            we_q <= 1'b0;
            ld_q <= 1'b0;
            rd_q <= '0;
        end else if (!stall_i) begin
            // Decode zeroes rd for non-writers
            we_q <= rd_i != '0;
            ld_q <= op_i == OP_LW;
            rd_q <= rd_i;
        end else if (ld_q) begin
            // Load data is on the bus only this cycle
            ld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            res_q <= alu_res;
        end else if (ld_q) begin
            res_q <= bus_rdata_i;
        end
    end

    assign rf_we_o    = we_q;
    assign rf_rd_o    = rd_q;
    assign rf_wdata_o = ld_q ? bus_rdata_i : res_q;

endmodule

/* design/rv_core.sv */
// Top level of the four-stage RV32I core, one shared memory bus for fetch and data
`timescale 1ns/1ns

module rv_core
    import rv_pkg::*;
#(
    parameter word_t RESET_ADDR = '0
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  stall_i,
    input  word_t bus_rdata_i,
    output logic  bus_en_o,
    output logic  bus_we_o,
    output word_t bus_addr_o,
    output word_t bus_wdata_o
);

    ////////////////////////////////////////////////////////////
    // Stage to stage signals
    ////////////////////////////////////////////////////////////

    // Fetch side
    logic     fetch_req;
    logic     fetch_gnt;
    word_t    fetch_addr;
    word_t    instr;
    logic     instr_valid;
    word_t    pc_id;

    // Decode and register bank
    logic     hazard;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;

    // Decode to execute
    op_e      op_ex;
    word_t    opa;
    word_t    opb;
    word_t    store_data;
    word_t    imm;
    word_t    pc_ex;
    reg_idx_t rd_ex;

    // Execute outputs
    logic     data_req;
    logic     data_we;
    word_t    data_addr;
    word_t    data_wdata;
    logic     redirect;
    word_t    redirect_target;
    logic     rf_we;
    reg_idx_t rf_rd;
    word_t    rf_wdata;

    ////////////////////////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////////////////////////

    fetch_unit #(
        .RESET_ADDR (RESET_ADDR)
    ) u_fetch (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .stall_i           (stall_i),
        .hazard_i          (hazard),
        .redirect_i        (redirect),
        .redirect_target_i (redirect_target),
        .fetch_gnt_i       (fetch_gnt),
        .bus_rdata_i       (bus_rdata_i),
        .fetch_req_o       (fetch_req),
        .fetch_addr_o      (fetch_addr),
        .instr_o           (instr),
        .instr_valid_o     (instr_valid),
        .pc_o              (pc_id)
    );

    decode_unit u_decode (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .pc_i          (pc_id),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .flush_i       (redirect),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .hazard_o      (hazard),
        .op_o          (op_ex),
        .opa_o         (opa),
        .opb_o         (opb),
        .store_data_o  (store_data),
        .imm_o         (imm),
        .pc_ex_o       (pc_ex),
        .rd_o          (rd_ex)
    );

    reg_bank u_regs (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .we_i       (rf_we),
        .rd_i       (rf_rd),
        .wdata_i    (rf_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exec_unit u_exec (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .stall_i           (stall_i),
        .op_i              (op_ex),
        .opa_i             (opa),
        .opb_i             (opb),
        .store_data_i      (store_data),
        .imm_i             (imm),
        .pc_i              (pc_ex),
        .rd_i              (rd_ex),
        .bus_rdata_i       (bus_rdata_i),
        .data_req_o        (data_req),
        .data_we_o         (data_we),
        .data_addr_o       (data_addr),
        .data_wdata_o      (data_wdata),
        .redirect_o        (redirect),
        .redirect_target_o (redirect_target),
        .rf_we_o           (rf_we),
        .rf_rd_o           (rf_rd),
        .rf_wdata_o        (rf_wdata)
    );

    // Data side always beats fetch on the shared bus
    mem_arbiter u_arb (
        .fetch_req_i  (fetch_req),
        .fetch_addr_i (fetch_addr),
        .data_req_i   (data_req),
        .data_we_i    (data_we),
        .data_addr_i  (data_addr),
        .data_wdata_i (data_wdata),
        .fetch_gnt_o  (fetch_gnt),
        .bus_en_o     (bus_en_o),
        .bus_we_o     (bus_we_o),
        .bus_addr_o   (bus_addr_o),
        .bus_wdata_o  (bus_wdata_o)
    );

endmodule

/* tests/rv_core_checker.sv */
// Bound assertions on the core's shared bus arbitration, attached to every rv_core instance
`timescale 1ns/1ns

module rv_core_checker (
    input logic clk_i,
    input logic arst_n_i,
    input logic fetch_gnt_i,
    input logic data_req_i,
    input logic bus_en_i,
    input logic bus_we_i
);

    ////////////////////////////////////////////////////////////
    // Arbiter properties
    ////////////////////////////////////////////////////////////

    // Data side owns the bus, fetch never granted alongside it
    gnt_excl_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fetch_gnt_i |-> !data_req_i)
        else $error("fetch grant given while a data request is present");

    // A write is always an enabled access
    we_en_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        bus_we_i |-> bus_en_i)
        else $error("bus write enable without bus enable");

    // Quiet bus under reset
    rst_idle_a: assert property (@(posedge clk_i)
        !arst_n_i |-> !bus_en_i)
        else $error("bus enabled while reset is held");

endmodule

// Arbiter nets live in the core, where the clock and reset are also visible
bind rv_core rv_core_checker i_checker (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .fetch_gnt_i (fetch_gnt),
    .data_req_i  (data_req),
    .bus_en_i    (bus_en_o),
    .bus_we_i    (bus_we_o)
);

/* tests/tb_rv_core.sv */
// Testbench for rv_core that runs a program from a shared memory model and checks every store
`timescale 1ns/1ns

module tb_rv_core
    import rv_pkg::*;
();

    localparam word_t RESET_ADDR       = 32'h0000_0040;
    localparam word_t DATA_BASE        = 32'h0000_0200;
    localparam int    CLK_PERIOD       = 20;
    localparam int    RESET_CYCLES     = 8;
    localparam int    MEM_WORDS        = 256;
    localparam int    CYCLES_PER_INSTR = 40;

    // DUT ports
    logic  clk_i;
    logic  arst_n_i;
    logic  stall_i;
    word_t bus_rdata_i;
    logic  bus_en_o;
    logic  bus_we_o;
    word_t bus_addr_o;
    word_t bus_wdata_o;

    // Memory model and reference state
    word_t mem      [MEM_WORDS];
    word_t ref_mem  [MEM_WORDS];
    word_t ref_regs [32];
    word_t exp_addr_q [$];
    word_t exp_data_q [$];

    integer seed;
    int     value_errors;
    int     other_errors;
    int     stores_seen;
    int     n_expected;
    int     prog_len;
    word_t  load_ptr;
    word_t  exp_a;
    word_t  exp_d;
    logic   prog_ready = 1'b0;
    logic   seen_first = 1'b0;

    rv_core #(
        .RESET_ADDR (RESET_ADDR)
    ) i_dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .stall_i     (stall_i),
        .bus_rdata_i (bus_rdata_i),
        .bus_en_o    (bus_en_o),
        .bus_we_o    (bus_we_o),
        .bus_addr_o  (bus_addr_o),
        .bus_wdata_o (bus_wdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////

    function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic word_t i_type(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t s_type(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(int rd, int imm20);
        return {imm20[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic word_t j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    // Low two bits stay zero, so stray fetches decode as no operation
    function automatic word_t fill_word(int idx);
        word_t byte_addr;
        byte_addr = word_t'(idx) << 2;
        return 32'hA5A5_0000 ^ byte_addr;
    endfunction

    task automatic put_instr(input word_t w);
        mem[load_ptr[9:2]] = w;
        load_ptr = load_ptr + 32'd4;
        prog_len++;
    endtask

    ////////////////////////////////////////////////////////////
    // Program with x10 as the store base
    ////////////////////////////////////////////////////////////

    task automatic build_program();
        put_instr(i_type(OPC_OP_IMM, 3'b000, 10, 0, DATA_BASE));
        put_instr(i_type(OPC_OP_IMM, 3'b000, 1, 0, 1443));
        put_instr(i_type(OPC_OP_IMM, 3'b000, 2, 0, -291));
        // ALU results, each consumer right behind its producer
        put_instr(r_type(7'b0000000, 3'b000, 3, 1, 2));
        put_instr(s_type(3, 10, 0));
        put_instr(r_type(7'b0100000, 3'b000, 4, 1, 2));
        put_instr(s_type(4, 10, 4));
        put_instr(r_type(7'b0000000, 3'b111, 5, 3, 4));
        put_instr(s_type(5, 10, 8));
        put_instr(r_type(7'b0000000, 3'b110, 6, 1, 2));
        put_instr(s_type(6, 10, 12));
        put_instr(r_type(7'b0000000, 3'b100, 7, 5, 6));
        put_instr(s_type(7, 10, 16));
        put_instr(r_type(7'b0000000, 3'b010, 8, 2, 1));
        put_instr(s_type(8, 10, 20));
        put_instr(u_type(9, 32'hABCDE));
        put_instr(i_type(OPC_OP_IMM, 3'b000, 9, 9, 32'h123));
        put_instr(s_type(9, 10, 24));
        // Write to x0 that has long retired when x0 is stored below
        put_instr(i_type(OPC_OP_IMM, 3'b000, 0, 0, 55));
        // Load then immediate use
        put_instr(i_type(OPC_LOAD, 3'b010, 11, 10, 64));
        put_instr(r_type(7'b0000000, 3'b000, 12, 11, 1));
        put_instr(s_type(12, 10, 28));
        // x0 still reads as zero
        put_instr(s_type(0, 10, 32));
        // Taken BEQ over two stores
        put_instr(b_type(3'b000, 1, 1, 12));
        put_instr(s_type(1, 10, 36));
        put_instr(s_type(2, 10, 36));
        // Taken BNE, then an untaken BEQ
        put_instr(b_type(3'b001, 1, 2, 8));
        put_instr(s_type(1, 10, 40));
        put_instr(b_type(3'b000, 1, 2, 8));
        put_instr(s_type(8, 10, 36));
        // JAL over one store with the link stored after
        put_instr(j_type(13, 8));
        put_instr(s_type(1, 10, 44));
        put_instr(s_type(13, 10, 40));
        put_instr(i_type(OPC_LOAD, 3'b010, 14, 10, 0));
        put_instr(s_type(14, 10, 44));
        put_instr(r_type(7'b0000000, 3'b010, 15, 1, 2));
        put_instr(s_type(15, 10, 48));
        // Park in a self loop
        put_instr(j_type(0, 0));
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model filling the expected store queues
    ////////////////////////////////////////////////////////////

    function automatic int run_reference();
        word_t      pc;
        word_t      next_pc;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      addr;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        logic       wr;
        int         n_stores;
        n_stores = 0;
        pc = RESET_ADDR;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int step = 0; step < 1000; step++) begin
            ins     = ref_mem[pc[9:2]];
            opc     = ins[6:0];
            rd      = ins[11:7];
            f3      = ins[14:12];
            f7      = ins[31:25];
            a       = ref_regs[ins[19:15]];
            b       = ref_regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            res     = '0;
            case (opc)
                OPC_OP: begin
                    wr = 1'b1;
                    case ({f7, f3})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_111: res = a & b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         wr = 1'b0;
                    endcase
                end
                OPC_OP_IMM: begin
                    wr  = f3 == 3'b000;
                    res = a + imm_i;
                end
                OPC_LUI: begin
                    wr  = 1'b1;
                    res = {ins[31:12], 12'h000};
                end
                OPC_LOAD: begin
                    addr = a + imm_i;
                    wr   = f3 == 3'b010;
                    res  = ref_mem[addr[9:2]];
                end
                OPC_STORE: begin
                    if (f3 == 3'b010) begin
                        addr = a + imm_s;
                        ref_mem[addr[9:2]] = b;
                        exp_addr_q.push_back(addr);
                        exp_data_q.push_back(b);
                        n_stores++;
                    end
                end
                OPC_BRANCH: begin
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                        next_pc = pc + imm_b;
                    end
                end
                OPC_JAL: begin
                    wr      = 1'b1;
                    res     = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 5'd0) begin
                ref_regs[rd] = res;
            end
            // Self loop marks the end
            if (next_pc == pc) begin
                break;
            end
            pc = next_pc;
        end
        return n_stores;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checking and reporting
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic report_counts();
        $display("Stores seen %0d of %0d, value errors %0d, other errors %0d",
                 stores_seen, n_expected, value_errors, other_errors);
    endtask

    // Memory answers one cycle after the address
    always @(posedge clk_i) begin
        if (bus_en_o) begin
            if (bus_we_o) begin
                mem[bus_addr_o[9:2]] = bus_wdata_o;
            end else begin
                bus_rdata_i <= mem[bus_addr_o[9:2]];
            end
        end
    end

    // Random stall after reset
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            stall_i <= (($random(seed) & 3) == 0);
        end
    end

    // Bus monitor for the first access and every store
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            if (bus_en_o || bus_we_o) begin
                other_errors++;
                $display("Bus is active while reset is held, at %0t ns", $time);
            end
        end else if (bus_en_o) begin
            if (!seen_first) begin
                seen_first = 1'b1;
                if (bus_we_o) begin
                    other_errors++;
                    $display("First bus access after reset is a write, at %0t ns", $time);
                end
                check_value("first fetch address", bus_addr_o, RESET_ADDR);
            end
            if (bus_we_o) begin
                stores_seen++;
                if (exp_addr_q.size() == 0) begin
                    other_errors++;
                    $display("Store of %h to %h at %0t ns was not expected",
                             bus_wdata_o, bus_addr_o, $time);
                end else begin
                    exp_a = exp_addr_q.pop_front();
                    exp_d = exp_data_q.pop_front();
                    check_value("store address", bus_addr_o, exp_a);
                    check_value("store data", bus_wdata_o, exp_d);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        word_t preload_addr;
        arst_n_i     <= 1'b0;
        stall_i      <= 1'b0;
        bus_rdata_i  <= '0;
        seed         = 76;
        value_errors = 0;
        other_errors = 0;
        stores_seen  = 0;
        prog_len     = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i[7:0]] = fill_word(i);
        end
        load_ptr = RESET_ADDR;
        build_program();
        // Word read by the first load
        preload_addr = DATA_BASE + 32'd64;
        mem[preload_addr[9:2]] = 32'h1357_9BDF;
        ref_mem    = mem;
        n_expected = run_reference();
        prog_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;
        wait (stores_seen >= n_expected);
        // Core parks in its self loop so any later store is extra
        repeat (20) @(posedge clk_i);
        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        longint limit_ns;
        wait (prog_ready);
        limit_ns = longint'(prog_len * CYCLES_PER_INSTR + RESET_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout after %0d ns, the program did not reach all of its stores", limit_ns);
        report_counts();
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* all.f */
design/rv_pkg.sv
design/mem_arbiter.sv
design/reg_bank.sv
design/fetch_unit.sv
design/decode_unit.sv
design/exec_unit.sv
design/rv_core.sv
tests/rv_core_checker.sv
tests/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build the core and its testbench with Verilator, run it, pass only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f all.f -o sim_rv_core

out=$(./obj_dir/sim_rv_core 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation PASSED"
